/* hdl/audio_board_top.sv */
// Board top level with key and LED pin inversion, mic receiver, tone, mixer and I2S out

`timescale 1ns/1ns
`default_nettype none

`include "audio_macros.svh"

module audio_board_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [board_pkg::KEY_W-1:0] KEY_N,
    input  logic                        MIC_SDO,
    output logic [board_pkg::LED_W-1:0] LED_N,
    output logic                        MIC_CS,
    output logic                        MIC_SCK,
    output logic                        I2S_MCLK,
    output logic                        I2S_BCLK,
    output logic                        I2S_LRCLK,
    output logic                        I2S_SDATA
);

    board_pkg::key_t      key;
    board_pkg::led_t      led;
    audio_pkg::mic_code_t mic_value;
    logic                 mic_valid;
    audio_pkg::pcm_t      tone;
    audio_pkg::pcm_t      sound;
    logic                 frame_tick;

    // ------------------------------
    // Active-low pins

    assign key   = ~KEY_N;
    assign LED_N = ~led;

    // ------------------------------
    // Audio path

    pmod_mic3_spi_receiver i_mic (
        .clk    (clk),
        .arst_n (arst_n),
        .sdo    (MIC_SDO),
        .cs     (MIC_CS),
        .sck    (MIC_SCK),
        .value  (mic_value),
        .valid  (mic_valid)
    );

    key_tone_gen i_tone (
        .clk        (clk),
        .arst_n     (arst_n),
        .key        (key),
        .frame_tick (frame_tick),   // Paced by the DAC frame
        .tone       (tone)
    );

    audio_mixer i_mixer (
        .clk       (clk),
        .arst_n    (arst_n),
        .mic_value (mic_value),
        .mic_valid (mic_valid),
        .tone      (tone),
        .sound     (sound),
        .led       (led)
    );

    i2s_audio_out i_audio_out (
        .clk        (clk),
        .arst_n     (arst_n),
        .sample     (sound),
        .mclk       (I2S_MCLK),
        .bclk       (I2S_BCLK),
        .lrclk      (I2S_LRCLK),
        .sdata      (I2S_SDATA),
        .frame_tick (frame_tick)
    );

endmodule

`default_nettype wire

/* hdl/audio_macros.svh */
// Clock, SPI and I2S divider, frame length, tone and microphone scaling constants

`ifndef AUDIO_MACROS_SVH
`define AUDIO_MACROS_SVH

// ------------------------------
// System clock

`define CLK_MHZ         50      // Nominal board clock

// ------------------------------
// PmodMIC3 SPI link

`define SPI_DIV         4       // Clocks per sck period
`define MIC_FRAME_CLKS  80      // Clocks per conversion
`define MIC_BITS        16      // Leading zeros plus 12 data bits

// ------------------------------
// I2S link and mixing

`define I2S_DIV         4       // Clocks per bclk period
`define I2S_SLOT_BITS   16      // Bits per channel slot
`define TONE_AMP        4096    // Square wave peak
`define MIC_OFFSET      2048    // ADC midscale
`define MIC_SHIFT       3       // Gain on the centered mic value

`endif

/* hdl/audio_mixer.sv */
// Mic offset removal and gain, saturating mix with the tone, LED level meter

`timescale 1ns/1ns
`default_nettype none

`include "audio_macros.svh"

module audio_mixer (
    input  logic                 clk,
    input  logic                 arst_n,
    input  audio_pkg::mic_code_t mic_value,
    input  logic                 mic_valid,
    input  audio_pkg::pcm_t      tone,
    output audio_pkg::pcm_t      sound,
    output board_pkg::led_t      led
);

    localparam int CODE_W  = audio_pkg::MIC_CODE_W;
    localparam int PCM_W   = audio_pkg::PCM_W;
    localparam int SUM_W   = PCM_W + 1;     // One guard bit for the sum
    localparam int LED_LSB = 11;            // First LED at 2048

    localparam logic signed [CODE_W:0] OFFSET  = `MIC_OFFSET;
    localparam audio_pkg::pcm_t         PCM_MAX = {1'b0, {(PCM_W-1){1'b1}}};
    localparam audio_pkg::pcm_t         PCM_MIN = {1'b1, {(PCM_W-1){1'b0}}};

    audio_pkg::mic_code_t    mic_hold;      // Last valid conversion
    audio_pkg::mic_code_t    mic_code;
    logic signed [CODE_W:0]  mic_centered;
    logic signed [SUM_W-1:0] mic_scaled;
    logic signed [SUM_W-1:0] sum;
    audio_pkg::pcm_t         sound_next;
    logic [PCM_W-1:0]        magnitude;
    board_pkg::led_t         led_next;

    // ------------------------------
    // Mix path

    assign mic_code     = mic_valid ? mic_value : mic_hold;   // Fresh code goes straight in
    assign mic_centered = $signed({1'b0, mic_code}) - OFFSET;
    assign mic_scaled   = SUM_W'(mic_centered) <<< `MIC_SHIFT;
    assign sum          = mic_scaled + SUM_W'(tone);

    always_comb begin
        if (sum[SUM_W-1] != sum[SUM_W-2]) begin
            sound_next = sum[SUM_W-1] ? PCM_MIN : PCM_MAX;    // Clip on overflow
        end else begin
            sound_next = sum[SUM_W-2:0];
        end
        magnitude = sound_next[PCM_W-1] ? -sound_next : sound_next;  // -32768 maps to 32768
        for (int i = 0; i < board_pkg::LED_W; i++) begin
            led_next[i] = magnitude >= (PCM_W'(1) << (LED_LSB + i));
        end
    end

    // ------------------------------
    // Output registers

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mic_hold <= audio_pkg::mic_code_t'(`MIC_OFFSET);
            sound    <= '0;
            led      <= '0;
        end else begin
            if (mic_valid) begin
                mic_hold <= mic_value;
            end
            sound <= sound_next;
            led   <= led_next;
        end
    end

endmodule

`default_nettype wire

/* hdl/audio_pkg.sv */
// Sample types for microphone ADC codes and PCM audio words

`default_nettype none

package audio_pkg;

    // ------------------------------
    // Widths

    localparam int MIC_CODE_W = 12;   // PmodMIC3 ADC resolution
    localparam int PCM_W      = 16;   // DAC word

    // ------------------------------
    // Types

    // Offset binary, midscale is silence
    typedef logic        [MIC_CODE_W-1:0] mic_code_t;

    typedef logic signed [PCM_W-1:0]      pcm_t;        // Two's complement sample

endpackage

`default_nettype wire

/* hdl/board_pkg.sv */
// Board I/O types for the push keys and the LED row

`default_nettype none

package board_pkg;

    // ------------------------------
    // Widths

    localparam int KEY_W = 4;   // Push keys on the board
    localparam int LED_W = 4;   // Level meter LEDs

    // ------------------------------
    // Types, both active high

    typedef logic [KEY_W-1:0] key_t;    // Pressed key reads 1
    typedef logic [LED_W-1:0] led_t;    // Lit LED is 1

endpackage

`default_nettype wire

/* hdl/i2s_audio_out.sv */
// I2S transmitter generating mclk, bclk, lrclk and sdata from one 16-bit sample

`timescale 1ns/1ns
`default_nettype none

`include "audio_macros.svh"

module i2s_audio_out (
    input  logic            clk,
    input  logic            arst_n,
    input  audio_pkg::pcm_t sample,
    output logic            mclk,
    output logic            bclk,
    output logic            lrclk,
    output logic            sdata,
    output logic            frame_tick
);

    localparam int DIV_W  = $clog2(`I2S_DIV);
    localparam int SLOT_W = $clog2(`I2S_SLOT_BITS);

    logic [DIV_W-1:0]  div_cnt;     // Position in the bclk period
    logic [SLOT_W:0]   bit_cnt;     // Left slot then right slot, MSB picks lrclk
    logic [SLOT_W-1:0] slot_pos;
    logic [SLOT_W-1:0] bit_sel;
    logic              bit_start;   // bclk falls on this edge
    logic              frame_start;
    audio_pkg::pcm_t   sample_q;    // Word sent in both slots

    assign slot_pos    = bit_cnt[SLOT_W-1:0];
    assign bit_start   = (div_cnt == '0);
    assign frame_start = bit_start && (bit_cnt == '0);

    // One bit of I2S delay, so position 0 carries the LSB of the previous slot
    // and position 1 the MSB; the subtraction wraps 16 to 0
    assign bit_sel = SLOT_W'(`I2S_SLOT_BITS) - slot_pos;

    // ------------------------------
    // Dividers

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            bit_cnt <= '0;
        end else if (div_cnt == DIV_W'(`I2S_DIV - 1)) begin
            div_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;      // Wraps after the right slot
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ------------------------------
    // Clocks, frame strobe and data

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mclk       <= 1'b0;
            bclk       <= 1'b0;
            lrclk      <= 1'b0;
            sdata      <= 1'b0;
            frame_tick <= 1'b0;
            sample_q   <= '0;
        end else begin
            mclk       <= div_cnt[0];                               // clk / 2
            bclk       <= div_cnt >= DIV_W'(`I2S_DIV / 2);          // Rises mid-period
            lrclk      <= bit_cnt[SLOT_W];                          // Low for left
            frame_tick <= frame_start;                              // Same edge as lrclk fall
            if (frame_start) begin
                sample_q <= sample;
            end
            if (bit_start) begin
                sdata <= sample_q[bit_sel];     // Old word still in place at frame start
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/key_tone_gen.sv */
// Square-wave tone generator with pitch chosen by the lowest pressed key

`timescale 1ns/1ns
`default_nettype none

`include "audio_macros.svh"

module key_tone_gen (
    input  logic            clk,
    input  logic            arst_n,
    input  board_pkg::key_t key,
    input  logic            frame_tick,
    output audio_pkg::pcm_t tone
);

    localparam int CNT_W = 4;

    localparam audio_pkg::pcm_t TONE_POS = audio_pkg::pcm_t'(`TONE_AMP);
    localparam audio_pkg::pcm_t TONE_NEG = audio_pkg::pcm_t'(-`TONE_AMP);

    logic [CNT_W-1:0] half_m1;      // Half period in frames, minus one
    logic [CNT_W-1:0] frame_cnt;
    logic             phase;        // 0 for the positive half
    logic             key_on;

    assign key_on = |key;

    // ------------------------------
    // Pitch select, key 0 wins

    always_comb begin
        if (key[0]) begin
            half_m1 = CNT_W'(1);        // 2 frames
        end else if (key[1]) begin
            half_m1 = CNT_W'(3);        // 4 frames
        end else if (key[2]) begin
            half_m1 = CNT_W'(7);        // 8 frames
        end else begin
            half_m1 = CNT_W'(15);       // Key 3
        end
    end

    // ------------------------------
    // Waveform, stepped once per frame

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            frame_cnt <= '0;
            phase     <= 1'b0;
            tone      <= '0;
        end else if (frame_tick) begin
            if (!key_on) begin
                frame_cnt <= '0;        // Next tone starts on the positive half
                phase     <= 1'b0;
                tone      <= '0;
            end else begin
                tone <= phase ? TONE_NEG : TONE_POS;
                // Also catches a switch to a shorter half period mid-run
                if (frame_cnt >= half_m1) begin
                    frame_cnt <= '0;
                    phase     <= ~phase;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/pmod_mic3_spi_receiver.sv */
// SPI master reading one 12-bit PmodMIC3 conversion per frame

`timescale 1ns/1ns
`default_nettype none

`include "audio_macros.svh"

module pmod_mic3_spi_receiver (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 sdo,
    output logic                 cs,
    output logic                 sck,
    output audio_pkg::mic_code_t value,
    output logic                 valid
);

    localparam int FRAME_W = $clog2(`MIC_FRAME_CLKS);
    localparam int PHASE_W = $clog2(`SPI_DIV);
    localparam int BIT_W   = $clog2(`MIC_BITS);

    logic [FRAME_W-1:0]   frame_cnt;    // Position in the conversion
    logic [PHASE_W-1:0]   phase_cnt;    // Position in the sck period
    logic [BIT_W-1:0]     bit_cnt;
    logic                 window;       // cs low span
    logic                 sample_en;
    logic                 last_bit;
    logic                 done_q;
    logic [`MIC_BITS-1:0] shift_q;

    assign window    = frame_cnt < FRAME_W'(`MIC_BITS * `SPI_DIV);
    assign sample_en = window && (phase_cnt == PHASE_W'(`SPI_DIV / 2)); // sck rises here
    assign last_bit  = sample_en && (bit_cnt == BIT_W'(`MIC_BITS - 1));

    // ------------------------------
    // Counters, cs and sck

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            frame_cnt <= '0;
            phase_cnt <= '0;
            bit_cnt   <= '0;
            cs        <= 1'b1;
            sck       <= 1'b0;
        end else begin
            if (frame_cnt == FRAME_W'(`MIC_FRAME_CLKS - 1)) begin
                frame_cnt <= '0;
            end else begin
                frame_cnt <= frame_cnt + 1'b1;
            end

            if (!window) begin
                phase_cnt <= '0;                // Idle gap between conversions
                bit_cnt   <= '0;
            end else if (phase_cnt == PHASE_W'(`SPI_DIV - 1)) begin
                phase_cnt <= '0;
                bit_cnt   <= bit_cnt + 1'b1;
            end else begin
                phase_cnt <= phase_cnt + 1'b1;
            end

            cs  <= !window;
            sck <= window && (phase_cnt >= PHASE_W'(`SPI_DIV / 2));   // High in second half
        end
    end

    // ------------------------------
    // Data capture

    always_ff @(posedge clk) begin
        if (sample_en) begin
            shift_q <= {shift_q[`MIC_BITS-2:0], sdo};  // MSB first
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done_q <= 1'b0;
            value  <= audio_pkg::mic_code_t'(`MIC_OFFSET);  // Silence until first read
            valid  <= 1'b0;
        end else begin
            done_q <= last_bit;
            valid  <= done_q;
            if (done_q) begin
                value <= shift_q[audio_pkg::MIC_CODE_W-1:0];  // Drop the leading zeros
            end
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Compile and run the audio board testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_audio_board -o tb_audio_board

status=0
./obj_dir/tb_audio_board > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    exit "$status"
fi

/* src.f */
+incdir+hdl
hdl/audio_pkg.sv
hdl/board_pkg.sv
hdl/pmod_mic3_spi_receiver.sv
hdl/key_tone_gen.sv
hdl/audio_mixer.sv
hdl/i2s_audio_out.sv
hdl/audio_board_top.sv
testbench/pmod_mic3_model.sv
testbench/tb_audio_board.sv

/* testbench/pmod_mic3_model.sv */
// Behavioral PmodMIC3 ADC model shifting a 12-bit code out on sdo

`timescale 1ns/1ns
`default_nettype none

`include "audio_macros.svh"

module pmod_mic3_model (
    input  logic                 cs,
    input  logic                 sck,
    input  audio_pkg::mic_code_t code,
    output logic                 sdo
);

    logic [`MIC_BITS-1:0] frame_bits;   // Leading zeros then the code

    initial begin
        sdo        = 1'b0;
        frame_bits = '0;
    end

    // ------------------------------
    // Conversion start, first leading zero on sdo

    always @(negedge cs) begin
        frame_bits = `MIC_BITS'(code);      // Zero extension gives the four zeros
        sdo        = frame_bits[`MIC_BITS-1];
    end

    // Next bit on each sck fall while selected
    always @(negedge sck) begin
        if (!cs) begin
            frame_bits = {frame_bits[`MIC_BITS-2:0], 1'b0};
            sdo        = frame_bits[`MIC_BITS-1];
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_audio_board.sv */
// Audio board testbench with clock, reset, stimulus table, I2S decoder and checks

`timescale 1ns/1ns
`default_nettype none

`include "audio_macros.svh"

module tb_audio_board;

    localparam int FIXED_ROWS = 12;
    localparam int NUM_ROWS   = 20;
    localparam int FRAME_CLKS = 2 * `I2S_SLOT_BITS * `I2S_DIV;
    localparam int SETTLE     = 6;      // Frames until a new row reaches the DAC

    logic                 clk;
    logic                 arst_n;
    board_pkg::key_t      key_n;
    audio_pkg::mic_code_t mic_code;     // Code returned by the ADC model
    logic                 mic_sdo;
    board_pkg::led_t      led_n;
    logic                 mic_cs;
    logic                 mic_sck;
    logic                 i2s_mclk;
    logic                 i2s_bclk;
    logic                 i2s_lrclk;
    logic                 i2s_sdata;

    // Stimulus table
    audio_pkg::mic_code_t row_code [NUM_ROWS];
    board_pkg::key_t      row_key  [NUM_ROWS];
    int                   row_pos  [NUM_ROWS];  // Word with tone positive or off
    int                   row_neg  [NUM_ROWS];  // Word with tone negative

    // I2S decoder state
    audio_pkg::pcm_t shift_word     = '0;
    audio_pkg::pcm_t left_word      = '0;
    logic            last_lr        = 1'b0;
    int              frame_count    = 0;
    int              last_word      = 0;
    board_pkg::led_t led_mid        = '0;
    board_pkg::led_t led_prev       = '0;
    logic            led_prev_valid = 1'b0;
    logic            led_check_en;
    logic [15:0]     lfsr;

    // mclk monitor state
    logic            mclk_last      = 1'b0;
    logic            mclk_running   = 1'b0;

    audio_board_top DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .KEY_N     (key_n),
        .MIC_SDO   (mic_sdo),
        .LED_N     (led_n),
        .MIC_CS    (mic_cs),
        .MIC_SCK   (mic_sck),
        .I2S_MCLK  (i2s_mclk),
        .I2S_BCLK  (i2s_bclk),
        .I2S_LRCLK (i2s_lrclk),
        .I2S_SDATA (i2s_sdata)
    );

    pmod_mic3_model mic_adc (
        .cs   (mic_cs),
        .sck  (mic_sck),
        .code (mic_code),
        .sdo  (mic_sdo)
    );

    always #50 clk = ~clk;

    // ------------------------------
    // Reference rules

    function automatic int mix_value(input int code, input int tone);
        int v;
        v = (code - `MIC_OFFSET) * (2 ** `MIC_SHIFT) + tone;
        if (v > 32767) begin
            v = 32767;
        end else if (v < -32768) begin
            v = -32768;
        end
        return v;
    endfunction

    function automatic board_pkg::led_t led_pattern(input int word);
        int              mag;
        board_pkg::led_t led;
        mag = (word < 0) ? -word : word;
        for (int i = 0; i < 4; i++) begin
            led[i] = (mag >= (1 << (11 + i)));      // Thermometer from 2048 up
        end
        return led;
    endfunction

    function automatic int half_frames(input board_pkg::key_t key);
        int half;
        half = 0;
        for (int i = 3; i >= 0; i--) begin
            if (key[i]) begin
                half = 2 << i;      // Lowest index ends up winning
            end
        end
        return half;
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic draw_code(output audio_pkg::mic_code_t code);
        code = '0;
        for (int b = 0; b < 12; b++) begin
            lfsr = lfsr_step(lfsr);
            code = {code[10:0], lfsr[0]};
        end
    endtask

    task automatic fill_row(input int idx, input int code, input board_pkg::key_t key);
        int amp;
        amp           = (key != '0) ? `TONE_AMP : 0;
        row_code[idx] = audio_pkg::mic_code_t'(code);
        row_key[idx]  = key;
        row_pos[idx]  = mix_value(code, amp);
        row_neg[idx]  = mix_value(code, -amp);
    endtask

    // ------------------------------
    // Failure reports

    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    // ------------------------------
    // I2S decoder where each word ends with the LSB one bclk after the lrclk edge

    always @(posedge i2s_bclk) begin
        audio_pkg::pcm_t word;
        if (arst_n) begin
            if (i2s_lrclk != last_lr) begin
                word = {shift_word[14:0], i2s_sdata};
                if (!last_lr) begin
                    left_word = word;
                    led_mid   = led_n;      // Meter for the word of the next frame
                end else begin
                    assert (word == left_word) else report_error($sformatf(
                        "left word %0d differs from right word %0d", left_word, word));
                    if (led_check_en && led_prev_valid) begin
                        assert (led_prev == ~led_pattern(int'(word))) else report_error(
                            $sformatf("LED_N %b for word %0d", led_prev, word));
                    end
                    led_prev       = led_mid;
                    led_prev_valid = 1'b1;
                    last_word      = int'(word);
                    frame_count++;
                end
                last_lr = i2s_lrclk;
            end else begin
                shift_word = {shift_word[14:0], i2s_sdata};
            end
        end
    end

    // mclk runs at clk / 2 once it has started
    always @(negedge clk) begin
        if (mclk_running) begin
            assert (i2s_mclk != mclk_last) else report_error($sformatf(
                "I2S_MCLK stayed at %b for two clocks", i2s_mclk));
        end
        mclk_last = i2s_mclk;
        if (i2s_mclk === 1'b1) begin
            mclk_running = 1'b1;
        end
    end

    // ------------------------------
    // Waits and row checks

    task automatic wait_frames(input int count);
        int target;
        int clocks;
        target = frame_count + count;
        clocks = 0;
        while (frame_count < target) begin
            @(negedge clk);
            clocks++;
            if (clocks > (count + 2) * FRAME_CLKS) begin
                report_timeout("a decoded I2S frame");
            end
        end
    endtask

    task automatic check_steady(input int idx);
        for (int f = 0; f < 3; f++) begin
            wait_frames(1);
            assert (last_word == row_pos[idx]) else report_error($sformatf(
                "row %0d word %0d, expected %0d", idx, last_word, row_pos[idx]));
        end
    endtask

    task automatic check_tone_runs(input int idx);
        int   half;
        int   run;
        int   changes;
        int   frames;
        logic positive;
        logic last_positive;
        half          = half_frames(row_key[idx]);
        run           = 0;
        changes       = 0;
        frames        = 0;
        last_positive = 1'b0;
        while (changes < 3) begin
            wait_frames(1);
            frames++;
            assert (last_word == row_pos[idx] || last_word == row_neg[idx]) else
                report_error($sformatf("row %0d word %0d, expected %0d or %0d",
                    idx, last_word, row_pos[idx], row_neg[idx]));
            positive = (last_word == row_pos[idx]);
            if (frames > 1 && positive != last_positive) begin
                if (changes > 0) begin
                    assert (run == half) else report_error($sformatf(
                        "row %0d run of %0d frames, expected %0d", idx, run, half));
                end
                changes++;
                run = 0;
            end
            run++;
            last_positive = positive;
            if (frames > 4 * half + 8) begin
                report_timeout("the tone to change sign");
            end
        end
    endtask

    task automatic apply_row(input int idx);
        mic_code     = row_code[idx];
        key_n        = ~row_key[idx];
        led_check_en = 1'b0;
        wait_frames(SETTLE);
        led_check_en = 1'b1;
        if (row_key[idx] == '0) begin
            check_steady(idx);
        end else begin
            check_tone_runs(idx);
        end
        led_check_en = 1'b0;
    endtask

    // ------------------------------
    // Main sequence

    initial begin
        audio_pkg::mic_code_t code;
        clk          = 1'b0;
        arst_n       = 1'b0;
        key_n        = '1;                  // No key pressed
        mic_code     = audio_pkg::mic_code_t'(`MIC_OFFSET);
        led_check_en = 1'b0;
        lfsr         = 16'd59446;

        fill_row(0, 2048, 4'b0000);
        fill_row(1, 4095, 4'b0000);
        fill_row(2, 0, 4'b0000);
        fill_row(3, 2049, 4'b0000);
        fill_row(4, 2048, 4'b0001);
        fill_row(5, 2048, 4'b0010);
        fill_row(6, 2048, 4'b0100);
        fill_row(7, 2048, 4'b1000);
        fill_row(8, 4095, 4'b0001);
        fill_row(9, 0, 4'b0010);
        fill_row(10, 3000, 4'b0110);        // Key 1 wins over key 2
        fill_row(11, 1000, 4'b0000);
        for (int i = FIXED_ROWS; i < NUM_ROWS; i++) begin
            draw_code(code);
            fill_row(i, int'(code), (i % 2 == 1) ? 4'b0001 : 4'b0000);
        end

        repeat (4) @(negedge clk);
        assert (led_n == '1 && mic_cs && !mic_sck && !i2s_sdata && !i2s_lrclk &&
                !i2s_bclk && !i2s_mclk) else report_error($sformatf(
            "reset state LED_N %b cs %b sck %b sdata %b lrclk %b bclk %b mclk %b",
                led_n, mic_cs, mic_sck, i2s_sdata, i2s_lrclk, i2s_bclk, i2s_mclk));
        arst_n = 1'b1;

        wait_frames(1);
        assert (last_word == 0) else report_error($sformatf(
            "first frame word %0d, expected 0", last_word));
        assert (mclk_running) else report_error("I2S_MCLK never started toggling");

        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(i);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire
